//--- Makefile
# Verilator build for the CP0 testbench

VERILATOR ?= verilator
TOP       ?= cp0Tb
RTL_TOP   ?= cp0Top
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
LINTFLAGS ?= --lint-only --timing --timescale 1ns/1ps
SIMFLAGS  ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

SRCS     := $(shell cat $(FILELIST))
RTL_SRCS := $(shell grep '^design/' $(FILELIST))

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

$(OBJDIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

sim: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- design/cp0ExcCtrl.sv
// Status, Cause, EPC, BadVAddr and ErrorEPC registers
// Exception entry and ERET, interrupt request and user mode
`timescale 1ns/1ps
`default_nettype none

module cp0ExcCtrl (
    input  logic                clk,
    input  logic                rst,
    input  cp0ExcPkg::hwIntr_t  hwIntr_i,
    input  logic                timerIrq_i,
    input  logic                wen_i,
    input  cp0RegPkg::regAddr_t addr_i,
    input  cp0RegPkg::word_t    wdata_i,
    input  logic                excFlag_i,
    input  cp0ExcPkg::excType_t excType_i,
    input  cp0RegPkg::word_t    pc_i,
    input  cp0RegPkg::word_t    excBadAddr_i,
    input  cp0ExcPkg::cpNum_t   excCpNum_i,
    input  logic                excSave_i,
    input  logic                inSlot_i,
    output cp0RegPkg::word_t    status_o,
    output cp0RegPkg::word_t    cause_o,
    output cp0RegPkg::word_t    epc_o,
    output cp0RegPkg::word_t    badVAddr_o,
    output cp0RegPkg::word_t    errorEpc_o,
    output logic                excIntr_o,
    output logic                userMode_o
);
    import cp0RegPkg::*;
    import cp0ExcPkg::*;

    word_t    statusQ;     // Only StatusWriteMask bits ever set
    logic     causeBd;
    cpNum_t   causeCe;
    logic [7:0] causeIp;
    excCode_t causeExcCode;
    word_t    epcQ;
    word_t    badVAddrQ;
    word_t    errorEpcQ;

    excCode_t excCodeNext;
    logic     excEntry;
    logic     noExlErl;

    assign excEntry = (excType_i != ExcNone) && (excType_i != ExcEret);

    always_comb begin
        case (excType_i)
            ExcCpU:  excCodeNext = ExcCodeCpU;
            ExcRi:   excCodeNext = ExcCodeRi;
            ExcOv:   excCodeNext = ExcCodeOv;
            ExcTrap: excCodeNext = ExcCodeTr;
            ExcSys:  excCodeNext = ExcCodeSys;
            ExcBp:   excCodeNext = ExcCodeBp;
            ExcAdE:  excCodeNext = excSave_i ? ExcCodeAdEL : ExcCodeAdES;
            default: excCodeNext = ExcCodeInt;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            statusQ      <= StatusReset;
            causeBd      <= 1'b0;
            causeCe      <= '0;
            causeIp      <= '0;
            causeExcCode <= '0;
            epcQ         <= '0;
            badVAddrQ    <= '0;
            errorEpcQ    <= ErrorEpcReset;
        end else begin
            // IP7 shares its line with the timer
            causeIp[7:2] <= {hwIntr_i[HwIntrCount-1] | timerIrq_i, hwIntr_i[HwIntrCount-2:0]};

            if (excFlag_i) begin
                if (excEntry) begin
                    // Nested entry keeps the first EPC
                    if (!statusQ[StatusExl]) begin
                        epcQ    <= inSlot_i ? pc_i - 32'd4 : pc_i;
                        causeBd <= inSlot_i;
                    end
                    statusQ[StatusExl] <= 1'b1;
                    causeExcCode       <= excCodeNext;
                end
                if (excType_i == ExcEret)
                    statusQ[StatusExl] <= 1'b0;
                if (excType_i == ExcAdE)
                    badVAddrQ <= excBadAddr_i;
                if (excType_i == ExcCpU)
                    causeCe <= excCpNum_i;
            end else if (wen_i) begin
                case (addr_i)
                    RegStatus:   statusQ      <= wdata_i & StatusWriteMask;
                    RegCause:    causeIp[1:0] <= wdata_i[CauseIp +: 2];  // Soft interrupts
                    RegEpc:      epcQ         <= wdata_i;
                    RegBadVAddr: badVAddrQ    <= wdata_i;
                    RegErrorEpc: errorEpcQ    <= wdata_i;
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        cause_o = '0;
        cause_o[CauseBd]                          = causeBd;
        cause_o[CauseCe +: $bits(cpNum_t)]        = causeCe;
        cause_o[CauseIp +: 8]                     = causeIp;
        cause_o[CauseExcCode +: $bits(excCode_t)] = causeExcCode;
    end

    assign noExlErl   = !statusQ[StatusExl] && !statusQ[StatusErl];
    assign excIntr_o  = |(causeIp & statusQ[StatusIm +: 8]) && statusQ[StatusIe] && noExlErl;
    assign userMode_o = statusQ[StatusUm] && noExlErl;

    assign status_o   = statusQ;
    assign epc_o      = epcQ;
    assign badVAddr_o = badVAddrQ;
    assign errorEpc_o = errorEpcQ;

    // Entry sets EXL, which must hold off the request next cycle
    noIntrInExlA : assert property (@(posedge clk) disable iff (rst)
        excFlag_i && excEntry |=> !excIntr_o)
        else $error("interrupt request raised while EXL set");

    excTypeValidA : assert property (@(posedge clk) disable iff (rst)
        excFlag_i |-> excType_i != ExcNone)
        else $error("exception strobe without exception type");

endmodule

`default_nettype wire

//--- design/cp0ExcPkg.sv
// Exception kinds from the pipeline, Cause.ExcCode values
// and interrupt line widths
`default_nettype none

package cp0ExcPkg;

    localparam int HwIntrCount = 6;

    typedef logic [3:0]             excType_t;
    typedef logic [4:0]             excCode_t;
    typedef logic [HwIntrCount-1:0] hwIntr_t;
    typedef logic [1:0]             cpNum_t;

    // Exception kind as signalled with excFlag_i
    localparam excType_t ExcNone = 4'd0;
    localparam excType_t ExcIntr = 4'd1;
    localparam excType_t ExcCpU  = 4'd2;
    localparam excType_t ExcRi   = 4'd3;
    localparam excType_t ExcOv   = 4'd4;
    localparam excType_t ExcTrap = 4'd5;
    localparam excType_t ExcSys  = 4'd6;
    localparam excType_t ExcBp   = 4'd7;
    localparam excType_t ExcAdE  = 4'd8;
    localparam excType_t ExcEret = 4'd9;   // Return, not an entry

    // Architectural ExcCode
    localparam excCode_t ExcCodeInt  = 5'd0;
    localparam excCode_t ExcCodeAdEL = 5'd4;
    localparam excCode_t ExcCodeAdES = 5'd5;
    localparam excCode_t ExcCodeSys  = 5'd8;
    localparam excCode_t ExcCodeBp   = 5'd9;
    localparam excCode_t ExcCodeRi   = 5'd10;
    localparam excCode_t ExcCodeCpU  = 5'd11;
    localparam excCode_t ExcCodeOv   = 5'd12;
    localparam excCode_t ExcCodeTr   = 5'd13;

endpackage

`default_nettype wire

//--- design/cp0RegPkg.sv
// CP0 register numbers and the register word type
// Status/Cause field positions, reset values and constant ID words
`default_nettype none

package cp0RegPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;

    // Kept register numbers
    localparam regAddr_t RegBadVAddr = 5'd8;
    localparam regAddr_t RegCount    = 5'd9;
    localparam regAddr_t RegCompare  = 5'd11;
    localparam regAddr_t RegStatus   = 5'd12;
    localparam regAddr_t RegCause    = 5'd13;
    localparam regAddr_t RegEpc      = 5'd14;
    localparam regAddr_t RegPrId     = 5'd15;
    localparam regAddr_t RegConfig   = 5'd16;
    localparam regAddr_t RegErrorEpc = 5'd30;

    localparam int StatusCu0 = 28;
    localparam int StatusBev = 22;
    localparam int StatusIm  = 8;   // IM7..IM0 at 15:8
    localparam int StatusUm  = 4;
    localparam int StatusErl = 2;
    localparam int StatusExl = 1;
    localparam int StatusIe  = 0;

    localparam int CauseBd      = 31;
    localparam int CauseCe      = 28;   // 29:28
    localparam int CauseIp      = 8;    // 15:8
    localparam int CauseExcCode = 2;    // 6:2

    localparam word_t StatusWriteMask = (32'd1 << StatusCu0) | (32'd1 << StatusBev) |
                                        (32'hFF << StatusIm) | (32'd1 << StatusUm) |
                                        (32'd1 << StatusErl) | (32'd1 << StatusExl) |
                                        (32'd1 << StatusIe);

    // Boot from the uncached ROM vector with errors masked
    localparam word_t StatusReset   = (32'd1 << StatusBev) | (32'd1 << StatusErl);
    localparam word_t ErrorEpcReset = 32'hBFC0_0000;

    localparam word_t PrIdValue   = 32'h0001_8000;
    localparam word_t ConfigValue = 32'h8000_0082; // Config1 present, MT standard TLB, K0 = 2

endpackage

`default_nettype wire

//--- design/cp0RegRead.sv
// Combinational CP0 read multiplexer with constant PrId and Config
`timescale 1ns/1ps
`default_nettype none

module cp0RegRead (
    input  cp0RegPkg::regAddr_t addr_i,
    input  cp0RegPkg::word_t    count_i,
    input  cp0RegPkg::word_t    compare_i,
    input  cp0RegPkg::word_t    status_i,
    input  cp0RegPkg::word_t    cause_i,
    input  cp0RegPkg::word_t    epc_i,
    input  cp0RegPkg::word_t    badVAddr_i,
    input  cp0RegPkg::word_t    errorEpc_i,
    output cp0RegPkg::word_t    rdata_o
);
    import cp0RegPkg::*;

    always_comb begin
        case (addr_i)
            RegBadVAddr: rdata_o = badVAddr_i;
            RegCount:    rdata_o = count_i;
            RegCompare:  rdata_o = compare_i;
            RegStatus:   rdata_o = status_i;
            RegCause:    rdata_o = cause_i;
            RegEpc:      rdata_o = epc_i;
            RegPrId:     rdata_o = PrIdValue;
            RegConfig:   rdata_o = ConfigValue;   // Not writable here
            RegErrorEpc: rdata_o = errorEpc_i;
            default:     rdata_o = '0;            // TLB and cache registers gone
        endcase
    end

endmodule

`default_nettype wire

//--- design/cp0Timer.sv
// Count/Compare timer with the sticky timer interrupt
`timescale 1ns/1ps
`default_nettype none

module cp0Timer (
    input  logic                clk,
    input  logic                rst,
    input  logic                wen_i,
    input  cp0RegPkg::regAddr_t addr_i,
    input  cp0RegPkg::word_t    wdata_i,
    input  logic                excFlag_i,
    output cp0RegPkg::word_t    count_o,
    output cp0RegPkg::word_t    compare_o,
    output logic                timerIrq_o
);
    import cp0RegPkg::*;

    logic [$bits(word_t):0] countQ;    // Runs at twice the Count rate
    word_t                  compareQ;
    logic                   timerIrqQ;
    logic                   countWe;
    logic                   compareWe;
    logic                   match;

    // Exception in the same cycle wins over the write
    assign countWe   = wen_i && !excFlag_i && (addr_i == RegCount);
    assign compareWe = wen_i && !excFlag_i && (addr_i == RegCompare);

    assign count_o = countQ[$bits(word_t):1];
    assign match   = (count_o == compareQ) && (compareQ != '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            countQ    <= '0;
            compareQ  <= '0;
            timerIrqQ <= 1'b0;
        end else begin
            countQ <= countQ + 1'b1;
            if (match)
                timerIrqQ <= 1'b1;
            if (countWe)
                countQ <= {wdata_i, 1'b0};  // Half step cleared
            if (compareWe) begin
                compareQ  <= wdata_i;
                timerIrqQ <= 1'b0;          // Acknowledge
            end
        end
    end

    assign compare_o  = compareQ;
    assign timerIrq_o = timerIrqQ;

    // Only a Compare write may drop a pending timer interrupt
    irqStickyA : assert property (@(posedge clk) disable iff (rst)
        $fell(timerIrq_o) |-> $past(compareWe))
        else $error("timer interrupt fell without a Compare write");

endmodule

`default_nettype wire

//--- design/cp0Top.sv
// CP0 top level: timer, exception control and read path
`timescale 1ns/1ps
`default_nettype none

module cp0Top (
    input  logic                clk,
    input  logic                rst,
    input  cp0ExcPkg::hwIntr_t  hwIntr_i,
    input  cp0RegPkg::regAddr_t addr_i,
    input  logic                wen_i,
    input  cp0RegPkg::word_t    wdata_i,
    input  logic                excFlag_i,
    input  cp0ExcPkg::excType_t excType_i,
    input  cp0RegPkg::word_t    pc_i,
    input  cp0RegPkg::word_t    excBadAddr_i,
    input  cp0ExcPkg::cpNum_t   excCpNum_i,
    input  logic                excSave_i,
    input  logic                inSlot_i,
    output cp0RegPkg::word_t    rdata_o,
    output cp0RegPkg::word_t    status_o,
    output cp0RegPkg::word_t    cause_o,
    output cp0RegPkg::word_t    epc_o,
    output cp0RegPkg::word_t    errorEpc_o,
    output logic                excIntr_o,
    output logic                userMode_o
);
    import cp0RegPkg::*;

    word_t count;
    word_t compare;
    word_t badVAddr;
    logic  timerIrq;

    cp0Timer uTimer (
        .clk        (clk),
        .rst        (rst),
        .wen_i      (wen_i),
        .addr_i     (addr_i),
        .wdata_i    (wdata_i),
        .excFlag_i  (excFlag_i),
        .count_o    (count),
        .compare_o  (compare),
        .timerIrq_o (timerIrq)
    );

    cp0ExcCtrl uExcCtrl (
        .clk          (clk),
        .rst          (rst),
        .hwIntr_i     (hwIntr_i),
        .timerIrq_i   (timerIrq),
        .wen_i        (wen_i),
        .addr_i       (addr_i),
        .wdata_i      (wdata_i),
        .excFlag_i    (excFlag_i),
        .excType_i    (excType_i),
        .pc_i         (pc_i),
        .excBadAddr_i (excBadAddr_i),
        .excCpNum_i   (excCpNum_i),
        .excSave_i    (excSave_i),
        .inSlot_i     (inSlot_i),
        .status_o     (status_o),
        .cause_o      (cause_o),
        .epc_o        (epc_o),
        .badVAddr_o   (badVAddr),
        .errorEpc_o   (errorEpc_o),
        .excIntr_o    (excIntr_o),
        .userMode_o   (userMode_o)
    );

    cp0RegRead uRegRead (
        .addr_i     (addr_i),
        .count_i    (count),
        .compare_i  (compare),
        .status_i   (status_o),
        .cause_i    (cause_o),
        .epc_i      (epc_o),
        .badVAddr_i (badVAddr),
        .errorEpc_i (errorEpc_o),
        .rdata_o    (rdata_o)
    );

endmodule

`default_nettype wire

//--- dv/cp0Input.txt
# op addr data aux expect, all hex. W write, R read rdata_o, I hwIntr = aux, D idle data cycles
# M expect {userMode, excIntr}. E data = PC, aux {wen, cpNum, save, inSlot, type}, expect badAddr
R 0c 00000000 000 00400004
R 1e 00000000 000 bfc00000
M 00 00000000 000 00000000
R 0f 00000000 000 00018000
R 10 00000000 000 80000082
R 03 00000000 000 00000000
W 0e deadbeef 000 00000000
R 0e 00000000 000 deadbeef
W 08 12345678 000 00000000
R 08 00000000 000 12345678
W 1e 80001000 000 00000000
R 1e 00000000 000 80001000
W 0b 00ffff00 000 00000000
R 0b 00000000 000 00ffff00
W 0c ffffffff 000 00000000
R 0c 00000000 000 1040ff17
W 0d ffffffff 000 00000000
R 0d 00000000 000 00000300
W 0d 00000000 000 00000000
W 0c 00000011 000 00000000
M 00 00000000 000 00000002
W 0c 00000013 000 00000000
M 00 00000000 000 00000000
I 00 00000000 015 00000000
R 0d 00000000 000 00005400
W 0c 00000401 000 00000000
M 00 00000000 000 00000001
W 0c 00000405 000 00000000
M 00 00000000 000 00000000
I 00 00000000 000 00000000
W 09 00000100 000 00000000
D 00 00000007 000 00000000
R 09 00000000 000 00000103
W 0c 00008001 000 00000000
W 09 00000200 000 00000000
W 0b 00000204 000 00000000
D 00 0000000a 000 00000000
R 0d 00000000 000 00008000
M 00 00000000 000 00000001
W 0b 00000000 000 00000000
R 0d 00000000 000 00008000
R 0d 00000000 000 00000000
E 00 80001234 014 00000000
R 0e 00000000 000 80001230
R 0d 00000000 000 80000030
R 0c 00000000 000 00008003
E 00 80002000 006 00000000
R 0e 00000000 000 80001230
E 00 00000000 009 00000000
R 0c 00000000 000 00008001
E 00 80004000 028 00400003
R 08 00000000 000 00400003
R 0d 00000000 000 00000010
E 00 00000000 009 00000000
E 00 80005000 008 00000ff1
R 0d 00000000 000 00000014
R 08 00000000 000 00000ff1
E 0c 00000000 109 00000000
R 0c 00000000 000 00008001
E 0e 80006000 106 11111111
R 0e 00000000 000 80006000

//--- dv/cp0Tb.sv
// Testbench for the CP0 top level
// Replays operations and expected values from the stimulus file
`timescale 1ns/1ps
`default_nettype none

module cp0Tb;
    import cp0RegPkg::*;
    import cp0ExcPkg::*;

    localparam int    ClkPeriod   = 20;
    localparam int    ResetCycles = 8;
    localparam string DataFile    = "dv/cp0Input.txt";

    logic     clk;
    logic     rst;
    hwIntr_t  hwIntr;
    regAddr_t addr;
    logic     wen;
    word_t    wdata;
    logic     excFlag;
    excType_t excType;
    word_t    pc;
    word_t    excBadAddr;
    cpNum_t   excCpNum;
    logic     excSave;
    logic     inSlot;
    word_t    rdata;
    word_t    status;
    word_t    cause;
    word_t    epc;
    word_t    errorEpc;
    logic     excIntr;
    logic     userMode;

    // One entry per operation line
    logic [7:0]  opQ[$];
    logic [31:0] addrQ[$];
    logic [31:0] dataQ[$];
    logic [31:0] auxQ[$];
    logic [31:0] expQ[$];
    int          lineQ[$];

    int errorCount = 0;
    int checkCount = 0;
    int maxIdle    = 0;
    int timeLimit  = 0;   // ns

    cp0Top dut (
        .clk          (clk),
        .rst          (rst),
        .hwIntr_i     (hwIntr),
        .addr_i       (addr),
        .wen_i        (wen),
        .wdata_i      (wdata),
        .excFlag_i    (excFlag),
        .excType_i    (excType),
        .pc_i         (pc),
        .excBadAddr_i (excBadAddr),
        .excCpNum_i   (excCpNum),
        .excSave_i    (excSave),
        .inSlot_i     (inSlot),
        .rdata_o      (rdata),
        .status_o     (status),
        .cause_o      (cause),
        .epc_o        (epc),
        .errorEpc_o   (errorEpc),
        .excIntr_o    (excIntr),
        .userMode_o   (userMode)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    initial begin
        wait (timeLimit != 0);
        #(timeLimit);
        $display("timeout after %0d ns, the operation list did not complete", timeLimit);
        $display("sim failed");
        $finish;
    end

    task automatic checkValue(input string name, input logic [31:0] expVal,
                              input logic [31:0] gotVal, input int lineNo);
        checkCount++;
        if (gotVal !== expVal) begin
            errorCount++;
            $display("[FAIL] %s exp %h got %h (line %0d)", name, expVal, gotVal, lineNo);
        end
    endtask

    task automatic loadOps;
        int          fd;
        int          lineNo;
        int          fields;
        string       line;
        logic [7:0]  opc;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] x;
        logic [31:0] e;
        fd = $fopen(DataFile, "r");
        if (fd == 0) begin
            errorCount++;
            $display("could not open the stimulus file %s", DataFile);
        end else begin
            lineNo = 0;
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                lineNo++;
                if (line.len() > 1 && line.getc(0) != "#") begin
                    fields = $sscanf(line, "%c %h %h %h %h", opc, a, d, x, e);
                    if (fields == 5) begin
                        opQ.push_back(opc);
                        addrQ.push_back(a);
                        dataQ.push_back(d);
                        auxQ.push_back(x);
                        expQ.push_back(e);
                        lineQ.push_back(lineNo);
                        if (opc == "D" && int'(d) > maxIdle)
                            maxIdle = int'(d);
                    end else begin
                        errorCount++;
                        $display("line %0d of the stimulus file cannot be parsed", lineNo);
                    end
                end
            end
            $fclose(fd);
        end
        timeLimit = (opQ.size() * (maxIdle + 1) + ResetCycles + 10) * ClkPeriod;
    endtask

    // Called on a falling edge, returns on a later falling edge
    task automatic runOp(input int idx);
        logic [7:0]  op;
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] x;
        logic [31:0] e;
        int          ln;
        op = opQ[idx];
        a  = addrQ[idx];
        d  = dataQ[idx];
        x  = auxQ[idx];
        e  = expQ[idx];
        ln = lineQ[idx];
        case (op)
            "W": begin
                addr  = a[4:0];
                wdata = d;
                wen   = 1'b1;
                @(negedge clk);
                wen = 1'b0;
            end
            "R": begin
                addr = a[4:0];
                #(ClkPeriod / 4);   // Mid low phase
                checkValue("rdata_o", e, rdata, ln);
                case (a[4:0])       // Registers with their own top-level output
                    RegStatus:   checkValue("status_o", e, status, ln);
                    RegCause:    checkValue("cause_o", e, cause, ln);
                    RegEpc:      checkValue("epc_o", e, epc, ln);
                    RegErrorEpc: checkValue("errorEpc_o", e, errorEpc, ln);
                    default: ;
                endcase
                @(negedge clk);
            end
            "E": begin
                excFlag    = 1'b1;
                excType    = x[3:0];
                inSlot     = x[4];
                excSave    = x[5];
                excCpNum   = x[7:6];
                pc         = d;
                excBadAddr = e;
                if (x[8]) begin     // Software write in the same cycle
                    wen   = 1'b1;
                    addr  = a[4:0];
                    wdata = e;
                end
                @(negedge clk);
                excFlag = 1'b0;
                excType = ExcNone;
                wen     = 1'b0;
            end
            "I": begin
                hwIntr = x[HwIntrCount-1:0];
                @(negedge clk);
            end
            "D": repeat (d) @(negedge clk);
            "M": begin
                #(ClkPeriod / 4);
                checkValue("excIntr_o", {31'd0, e[0]}, {31'd0, excIntr}, ln);
                checkValue("userMode_o", {31'd0, e[1]}, {31'd0, userMode}, ln);
                @(negedge clk);
            end
            default: begin
                errorCount++;
                $display("line %0d holds an unknown operation %c", ln, op);
            end
        endcase
    endtask

    initial begin
        hwIntr     = '0;
        addr       = '0;
        wen        = 1'b0;
        wdata      = '0;
        excFlag    = 1'b0;
        excType    = ExcNone;
        pc         = '0;
        excBadAddr = '0;
        excCpNum   = '0;
        excSave    = 1'b0;
        inSlot     = 1'b0;
        rst        = 1'b1;
        loadOps();
        repeat (ResetCycles) @(negedge clk);
        rst = 1'b0;
        foreach (opQ[i])
            runOp(i);
        $display("%0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
design/cp0RegPkg.sv
design/cp0ExcPkg.sv
design/cp0Timer.sv
design/cp0ExcCtrl.sv
design/cp0RegRead.sv
design/cp0Top.sv
dv/cp0Tb.sv
